// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;
    localparam int XLEN   = 32;
    localparam int MEM_AW = 8;

    localparam logic [6:0] OPCODE_LOAD    = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE   = 7'b0100011;
    localparam logic [6:0] OPCODE_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPCODE_OP      = 7'b0110011;
    localparam logic [6:0] OPCODE_LUI     = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPCODE_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL     = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR    = 7'b1100111;
    localparam logic [6:0] OPCODE_MISCMEM = 7'b0001111;
    localparam logic [6:0] OPCODE_SYSTEM  = 7'b1110011;

    localparam logic [2:0] FUNCT3_ADD  = 3'd0;
    localparam logic [2:0] FUNCT3_SLL  = 3'd1;
    localparam logic [2:0] FUNCT3_SLT  = 3'd2;
    localparam logic [2:0] FUNCT3_SLTU = 3'd3;
    localparam logic [2:0] FUNCT3_XOR  = 3'd4;
    localparam logic [2:0] FUNCT3_SR   = 3'd5;
    localparam logic [2:0] FUNCT3_OR   = 3'd6;
    localparam logic [2:0] FUNCT3_AND  = 3'd7;

    localparam logic [2:0] FUNCT3_BEQ  = 3'd0;
    localparam logic [2:0] FUNCT3_BNE  = 3'd1;
    localparam logic [2:0] FUNCT3_BLT  = 3'd4;
    localparam logic [2:0] FUNCT3_BGE  = 3'd5;
    localparam logic [2:0] FUNCT3_BLTU = 3'd6;
    localparam logic [2:0] FUNCT3_BGEU = 3'd7;

    localparam logic [2:0] FUNCT3_LB  = 3'd0;
    localparam logic [2:0] FUNCT3_LH  = 3'd1;
    localparam logic [2:0] FUNCT3_LW  = 3'd2;
    localparam logic [2:0] FUNCT3_LBU = 3'd4;
    localparam logic [2:0] FUNCT3_LHU = 3'd5;
    localparam logic [2:0] FUNCT3_SB  = 3'd0;
    localparam logic [2:0] FUNCT3_SH  = 3'd1;
    localparam logic [2:0] FUNCT3_SW  = 3'd2;

    localparam logic [2:0] FUNCT3_JALR  = 3'd0;
    localparam logic [2:0] FUNCT3_FENCE = 3'd0;
    localparam logic [2:0] FUNCT3_ECALL = 3'd0;
    localparam logic [2:0] FUNCT3_CSRRW = 3'd1; // Immediate forms share the low bits.
    localparam logic [2:0] FUNCT3_CSRRS = 3'd2;
    localparam logic [2:0] FUNCT3_CSRRC = 3'd3;

    localparam logic [6:0]  FUNCT7_ADD = 7'b0000000;
    localparam logic [6:0]  FUNCT7_SUB = 7'b0100000;
    localparam logic [11:0] IMM_ECALL  = 12'h000;
    localparam logic [11:0] IMM_EBREAK = 12'h001;

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_FETCH = 3'd1;
    localparam logic [2:0] ST_FWAIT = 3'd2;
    localparam logic [2:0] ST_EXEC  = 3'd3;
    localparam logic [2:0] ST_MEM   = 3'd4;
    localparam logic [2:0] ST_MWAIT = 3'd5;
    localparam logic [2:0] ST_STOP  = 3'd6;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_t;
endpackage

`default_nettype wire

// ==== hw/inst_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module inst_decode import rv_pkg::*; (
    input  logic [XLEN-1:0] inst,
    output logic            invalid_inst,
    output logic [6:0]      opcode,
    output logic [2:0]      f3,
    output logic [4:0]      rd,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic [XLEN-1:0] imm,
    output logic [2:0]      op,
    output logic            mod
);
    rv_inst_t        iw;
    logic [6:0]      f7;
    logic [XLEN-1:0] ii;
    logic [XLEN-1:0] si;
    logic [XLEN-1:0] bi;
    logic [XLEN-1:0] ui;
    logic [XLEN-1:0] ji;
    logic            sub_or_sra;
    logic            shift_imm;
    logic            valid_f7;
    logic            valid_csr;
    logic            valid_call;
    logic            bad;

    assign iw     = inst;
    assign opcode = iw.r.opcode;
    assign f3     = iw.r.funct3;
    assign rd     = iw.r.rd;
    assign rs1    = iw.r.rs1;
    assign rs2    = iw.r.rs2;
    assign f7     = iw.r.funct7;

    assign ii = {{20{iw.i.imm11_0[11]}}, iw.i.imm11_0};
    assign si = {{20{iw.s.imm11_5[6]}}, iw.s.imm11_5, iw.s.imm4_0};
    assign bi = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5, iw.b.imm4_1, 1'b0};
    assign ui = {iw.u.imm31_12, 12'b0};
    assign ji = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11, iw.j.imm10_1, 1'b0};

    assign sub_or_sra = f3 == FUNCT3_ADD || f3 == FUNCT3_SR;
    assign shift_imm  = f3 == FUNCT3_SLL || f3 == FUNCT3_SR;
    assign valid_f7   = f7 == FUNCT7_ADD || (f7 == FUNCT7_SUB && sub_or_sra); // MUL fails here.
    assign valid_csr  = f3[1:0] == FUNCT3_CSRRW[1:0] || f3[1:0] == FUNCT3_CSRRS[1:0]
                     || f3[1:0] == FUNCT3_CSRRC[1:0];
    assign valid_call = f3 == FUNCT3_ECALL && iw.i.rd == 5'd0 && iw.i.rs1 == 5'd0
                     && (iw.i.imm11_0 == IMM_ECALL || iw.i.imm11_0 == IMM_EBREAK);

    always_comb begin
        imm = '0;
        op  = FUNCT3_ADD; // Address forming opcodes add.
        mod = 1'b0;
        bad = 1'b0;
        case (opcode)
            OPCODE_LUI, OPCODE_AUIPC: imm = ui;
            OPCODE_JAL: imm = ji;
            OPCODE_JALR: begin
                imm = ii;
                bad = f3 != FUNCT3_JALR;
            end
            OPCODE_BRANCH: begin
                imm = bi;
                bad = !(f3 inside {FUNCT3_BEQ, FUNCT3_BNE, FUNCT3_BLT,
                                   FUNCT3_BGE, FUNCT3_BLTU, FUNCT3_BGEU});
            end
            OPCODE_LOAD: begin
                imm = ii;
                bad = !(f3 inside {FUNCT3_LB, FUNCT3_LH, FUNCT3_LW, FUNCT3_LBU, FUNCT3_LHU});
            end
            OPCODE_STORE: begin
                imm = si;
                bad = !(f3 inside {FUNCT3_SB, FUNCT3_SH, FUNCT3_SW});
            end
            OPCODE_OPIMM: begin
                imm = ii;
                op  = f3;
                mod = f3 == FUNCT3_SR && f7[5]; // SRAI only.
                bad = shift_imm && !valid_f7;
            end
            OPCODE_OP: begin
                op  = f3;
                mod = f7[5];
                bad = !valid_f7;
            end
            OPCODE_MISCMEM: begin
                imm = ii;
                bad = f3 != FUNCT3_FENCE;
            end
            OPCODE_SYSTEM: begin
                imm = ii;
                bad = !(valid_call || valid_csr);
            end
            default: bad = 1'b1;
        endcase
    end

    assign invalid_inst = opcode[1:0] != 2'b11 || bad; // Compressed prefixes are rejected.

endmodule

`default_nettype wire

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_alu import rv_pkg::*; (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  logic [2:0]      op,
    input  logic            mod,
    output logic [XLEN-1:0] y
);
    logic [4:0]             shamt;
    logic signed [XLEN-1:0] sra;

    assign shamt = b[4:0];
    assign sra   = $signed(a) >>> shamt;

    always_comb begin
        case (op)
            FUNCT3_ADD:  y = mod ? a - b : a + b;
            FUNCT3_SLL:  y = a << shamt;
            FUNCT3_SLT:  y = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            FUNCT3_SLTU: y = {{(XLEN-1){1'b0}}, a < b};
            FUNCT3_XOR:  y = a ^ b;
            FUNCT3_SR:   y = mod ? sra : a >> shamt;
            FUNCT3_OR:   y = a | b;
            default:     y = a & b;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic            we,
    input  logic [XLEN-1:0] wd,
    output logic [XLEN-1:0] rd1,
    output logic [XLEN-1:0] rd2
);
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1]; // x0 is hardwired.
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hw/mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter import rv_pkg::*; (
    input  logic              host_req,
    input  logic              host_we,
    input  logic [MEM_AW-1:0] host_addr,
    input  logic [XLEN-1:0]   host_wdata,
    input  logic              dreq,
    input  logic              dwe,
    input  logic [MEM_AW-1:0] daddr,
    input  logic [XLEN-1:0]   dwdata,
    input  logic              freq,
    input  logic [MEM_AW-1:0] faddr,
    output logic              host_ack,
    output logic              dack,
    output logic              fack,
    output logic              ram_we,
    output logic [MEM_AW-1:0] ram_addr,
    output logic [XLEN-1:0]   ram_wdata
);
    assign host_ack = host_req;
    assign dack     = dreq && !host_req;
    assign fack     = freq && !host_req && !dreq;

    always_comb begin
        if (host_req) begin
            ram_we    = host_we;
            ram_addr  = host_addr;
            ram_wdata = host_wdata;
        end else if (dreq) begin
            ram_we    = dwe;
            ram_addr  = daddr;
            ram_wdata = dwdata;
        end else begin
            ram_we    = 1'b0; // Fetch or no request.
            ram_addr  = faddr;
            ram_wdata = dwdata;
        end
    end

endmodule

`default_nettype wire

// ==== hw/word_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_ram import rv_pkg::*; (
    input  logic              clk,
    input  logic              we,
    input  logic [MEM_AW-1:0] addr,
    input  logic [XLEN-1:0]   wdata,
    output logic [XLEN-1:0]   rdata
);
    logic [XLEN-1:0] mem [0:(1<<MEM_AW)-1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr]; // Old data on a write.
    end

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic [XLEN-1:0]   rdata,
    input  logic              dack,
    input  logic              fack,
    output logic              freq,
    output logic [MEM_AW-1:0] faddr,
    output logic              dreq,
    output logic              dwe,
    output logic [MEM_AW-1:0] daddr,
    output logic [XLEN-1:0]   dwdata,
    output logic              halted,
    output logic              trap
);
    logic [2:0]      state;
    logic [XLEN-1:0] pc;
    rv_inst_t        ir;
    logic            invalid_inst;
    logic [6:0]      opcode;
    logic [2:0]      f3;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic [2:0]      op;
    logic            mod;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] alu_y;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] next_pc;
    logic            take;
    logic            is_call;
    logic            is_mem;
    logic            rf_we;
    logic [XLEN-1:0] rf_wd;

    inst_decode u_inst_decode (
        .inst(ir), .invalid_inst(invalid_inst), .opcode(opcode), .f3(f3), .rd(rd),
        .rs1(rs1), .rs2(rs2), .imm(imm), .op(op), .mod(mod)
    );

    rv_alu u_rv_alu (
        .a(opcode == OPCODE_AUIPC ? pc : rd1), .b(opcode == OPCODE_OP ? rd2 : imm),
        .op(op), .mod(mod), .y(alu_y)
    );

    rv_regfile u_rv_regfile (
        .clk(clk), .rst_n(rst_n), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(rf_we), .wd(rf_wd), .rd1(rd1), .rd2(rd2)
    );

    assign pc_plus4 = pc + 32'd4;
    assign is_mem   = opcode == OPCODE_LOAD || opcode == OPCODE_STORE;
    assign is_call  = opcode == OPCODE_SYSTEM && ir.i.funct3 == FUNCT3_ECALL
                   && (ir.i.imm11_0 == IMM_ECALL || ir.i.imm11_0 == IMM_EBREAK);

    assign freq   = state == ST_FETCH;
    assign faddr  = pc[MEM_AW+1:2];
    assign dreq   = state == ST_MEM;
    assign dwe    = dreq && opcode == OPCODE_STORE;
    assign daddr  = alu_y[MEM_AW+1:2];
    assign dwdata = rd2;

    always_comb begin
        case (f3)
            FUNCT3_BEQ:  take = rd1 == rd2;
            FUNCT3_BNE:  take = rd1 != rd2;
            FUNCT3_BLT:  take = $signed(rd1) < $signed(rd2);
            FUNCT3_BGE:  take = $signed(rd1) >= $signed(rd2);
            FUNCT3_BLTU: take = rd1 < rd2;
            FUNCT3_BGEU: take = rd1 >= rd2;
            default:     take = 1'b0;
        endcase
        case (opcode)
            OPCODE_JAL:    next_pc = pc + imm;
            OPCODE_JALR:   next_pc = {alu_y[XLEN-1:1], 1'b0};
            OPCODE_BRANCH: next_pc = take ? pc + imm : pc_plus4;
            default:       next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        rf_we = 1'b0;
        rf_wd = alu_y;
        if (state == ST_MWAIT) begin
            rf_we = opcode == OPCODE_LOAD;
            rf_wd = rdata;
        end else if (state == ST_EXEC && !invalid_inst) begin
            case (opcode)
                OPCODE_LUI: begin
                    rf_we = 1'b1;
                    rf_wd = imm;
                end
                OPCODE_JAL, OPCODE_JALR: begin
                    rf_we = 1'b1;
                    rf_wd = pc_plus4; // Link address.
                end
                OPCODE_AUIPC, OPCODE_OP, OPCODE_OPIMM: rf_we = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_FWAIT) begin
            ir <= rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            pc     <= '0;
            halted <= 1'b0;
            trap   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (run) begin
                        state <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    if (fack) begin
                        state <= ST_FWAIT;
                    end
                end
                ST_FWAIT: state <= ST_EXEC;
                ST_EXEC: begin
                    if (invalid_inst) begin
                        trap  <= 1'b1;
                        state <= ST_STOP;
                    end else if (is_call) begin
                        halted <= 1'b1;
                        state  <= ST_STOP;
                    end else if (is_mem) begin
                        state <= ST_MEM;
                    end else begin
                        pc    <= next_pc;
                        state <= ST_FETCH;
                    end
                end
                ST_MEM: begin
                    if (dack) begin
                        state <= ST_MWAIT;
                    end
                end
                ST_MWAIT: begin
                    pc    <= pc_plus4;
                    state <= ST_FETCH;
                end
                ST_STOP: begin
                    if (!run) begin
                        state  <= ST_IDLE;
                        pc     <= '0;
                        halted <= 1'b0;
                        trap   <= 1'b0;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_system import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              host_req,
    input  logic              host_we,
    input  logic [MEM_AW-1:0] host_addr,
    input  logic [XLEN-1:0]   host_wdata,
    output logic              host_ack,
    output logic [XLEN-1:0]   host_rdata,
    output logic              halted,
    output logic              trap
);
    logic              freq;
    logic [MEM_AW-1:0] faddr;
    logic              fack;
    logic              dreq;
    logic              dwe;
    logic [MEM_AW-1:0] daddr;
    logic [XLEN-1:0]   dwdata;
    logic              dack;
    logic              ram_we;
    logic [MEM_AW-1:0] ram_addr;
    logic [XLEN-1:0]   ram_wdata;
    logic [XLEN-1:0]   ram_rdata;

    rv_core u_rv_core (
        .clk(clk), .rst_n(rst_n), .run(run), .rdata(ram_rdata), .dack(dack), .fack(fack),
        .freq(freq), .faddr(faddr), .dreq(dreq), .dwe(dwe), .daddr(daddr), .dwdata(dwdata),
        .halted(halted), .trap(trap)
    );

    mem_arbiter u_mem_arbiter (
        .host_req(host_req), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .dreq(dreq), .dwe(dwe), .daddr(daddr), .dwdata(dwdata),
        .freq(freq), .faddr(faddr), .host_ack(host_ack), .dack(dack), .fack(fack),
        .ram_we(ram_we), .ram_addr(ram_addr), .ram_wdata(ram_wdata)
    );

    word_ram u_word_ram (
        .clk(clk), .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
    );

    assign host_rdata = ram_rdata; // Valid the cycle after host_ack.

endmodule

`default_nettype wire

// ==== bench/tb_rv_system.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_rv_system import rv_pkg::*; ();
    logic              clk;
    logic              rst_n;
    logic              run;
    logic              host_req;
    logic              host_we;
    logic [MEM_AW-1:0] host_addr;
    logic [XLEN-1:0]   host_wdata;
    logic              host_ack;
    logic [XLEN-1:0]   host_rdata;
    logic              halted;
    logic              trap;

    int                fd;
    int                cycles;
    int                cycle_limit;
    int                runs;
    int                records;
    logic [7:0]        cmd;
    logic [XLEN-1:0]   arg_a;
    logic [XLEN-1:0]   arg_b;
    logic [XLEN-1:0]   rd_word;
    logic              done;
    logic              bad;
    logic              last_halted;
    logic              last_trap;

    rv_system u_rv_system (
        .clk(clk), .rst_n(rst_n), .run(run), .host_req(host_req), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .host_ack(host_ack),
        .host_rdata(host_rdata), .halted(halted), .trap(trap)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            abort_run($sformatf("Timeout, the tests did not finish within %0d cycles.",
                                cycle_limit));
        end
    end

    task automatic abort_run(input string why);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input logic [XLEN-1:0] actual, input logic [XLEN-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            abort_run("Value mismatch.");
        end
    endtask

    task automatic open_stim();
        fd = $fopen("bench/rv_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open bench/rv_stim.txt for reading.");
        end
    endtask

    task automatic skip_line();
        int c;
        c = $fgetc(fd);
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // Reads one record. A lone # starts a comment that runs to the line end.
    task automatic read_record(output logic [7:0] kind, output logic [XLEN-1:0] a,
                               output logic [XLEN-1:0] b, output logic at_end,
                               output logic malformed);
        int code;
        kind      = 8'h00;
        a         = '0;
        b         = '0;
        at_end    = 1'b0;
        malformed = 1'b0;
        code = $fscanf(fd, " %c", kind);
        while (code == 1 && kind == "#") begin
            skip_line();
            code = $fscanf(fd, " %c", kind);
        end
        if (code != 1) begin
            at_end = 1'b1;
        end else if (kind == "L" || kind == "C") begin
            malformed = $fscanf(fd, "%h %h", a, b) != 2;
        end else if (kind == "S") begin
            malformed = $fscanf(fd, "%d %d", a, b) != 2;
        end else if (kind != "R") begin
            malformed = 1'b1;
        end
    endtask

    task automatic host_access(input logic we, input logic [MEM_AW-1:0] addr,
                               input logic [XLEN-1:0] data, output logic [XLEN-1:0] q);
        @(negedge clk);
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = addr;
        host_wdata = data;
        @(posedge clk);
        while (!host_ack) begin
            @(posedge clk);
        end
        @(negedge clk);
        q        = host_rdata; // Read data lands one cycle after the grant.
        host_req = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic run_program();
        @(negedge clk);
        run = 1'b1;
        @(negedge clk);
        while (!halted && !trap) begin
            @(negedge clk);
        end
        last_halted = halted;
        last_trap   = trap;
        run = 1'b0; // Core drops back to IDLE on the next edge.
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        run         = 1'b0;
        host_req    = 1'b0;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        cycles      = 0;
        cycle_limit = 0;
        runs        = 0;
        records     = 0;
        last_halted = 1'b0;
        last_trap   = 1'b0;

        // First pass sizes the timeout.
        open_stim();
        read_record(cmd, arg_a, arg_b, done, bad);
        while (!done) begin
            if (bad) begin
                abort_run("Malformed record in bench/rv_stim.txt.");
            end
            records++;
            if (cmd == "R") begin
                runs++;
            end
            read_record(cmd, arg_a, arg_b, done, bad);
        end
        $fclose(fd);
        cycle_limit = 400 * runs + 4 * records + 20;

        open_stim();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        read_record(cmd, arg_a, arg_b, done, bad);
        while (!done) begin
            case (cmd)
                "L": host_access(1'b1, arg_a[MEM_AW-1:0], arg_b, rd_word);
                "C": begin
                    host_access(1'b0, arg_a[MEM_AW-1:0], '0, rd_word);
                    check_value(rd_word, arg_b,
                                $sformatf("memory word %02h", arg_a[MEM_AW-1:0]));
                end
                "S": begin
                    check_value({31'b0, last_halted}, arg_a, "halted");
                    check_value({31'b0, last_trap}, arg_b, "trap");
                end
                "R": run_program();
                default: abort_run("Unknown record type in bench/rv_stim.txt.");
            endcase
            read_record(cmd, arg_a, arg_b, done, bad);
        end
        $fclose(fd);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/rv_stim.txt ====
# L addr data writes a word from the host, C addr data reads one back and compares it (hex).
# R runs the program at word 0 until halted or trap, S halted trap is the expected status.
# Host path before any program.
L 00 CAFEF00D
L 43 DEADBEEF
L 80 A5A5A5A5
L FF 12345678
C 00 CAFEF00D
C 43 DEADBEEF
C 80 A5A5A5A5
C FF 12345678
# Arithmetic, results stored from byte 0x100 (word 40).
L 00 06400093 # addi x1, x0, 100
L 01 FF900113 # addi x2, x0, -7
L 02 002081B3 # add x3, x1, x2
L 03 40208233 # sub x4, x1, x2
L 04 001122B3 # slt x5, x2, x1
L 05 00113333 # sltu x6, x2, x1
L 06 40115393 # srai x7, x2, 1
L 07 00515433 # srl x8, x2, x5
L 08 0020C4B3 # xor x9, x1, x2
L 09 0020E533 # or x10, x1, x2
L 0A 0020F5B3 # and x11, x1, x2
L 0B 12345637 # lui x12, 0x12345
L 0C 00001697 # auipc x13, 1 at pc 0x30
L 0D 10302023 # sw x3, 0x100(x0)
L 0E 10402223 # sw x4, 0x104(x0)
L 0F 10502423 # sw x5, 0x108(x0)
L 10 10602623 # sw x6, 0x10c(x0)
L 11 10702823 # sw x7, 0x110(x0)
L 12 10802A23 # sw x8, 0x114(x0)
L 13 10902C23 # sw x9, 0x118(x0)
L 14 10A02E23 # sw x10, 0x11c(x0)
L 15 12B02023 # sw x11, 0x120(x0)
L 16 12C02223 # sw x12, 0x124(x0)
L 17 12D02423 # sw x13, 0x128(x0)
L 18 00000073 # ecall
R
S 1 0
C 40 0000005D
C 41 0000006B
C 42 00000001
C 43 00000000
C 44 FFFFFFFC
C 45 7FFFFFFC
C 46 FFFFFF9D
C 47 FFFFFFFD
C 48 00000060
C 49 12345000
C 4A 00001030
# Array sum with branches and jumps, x0 write first. Zero words trap on a wrong path.
L 50 55555555
L 60 00000005
L 61 00000007
L 62 00000100
L 63 00001000
L 00 00500013 # addi x0, x0, 5
L 01 14002023 # sw x0, 0x140(x0)
L 02 18000093 # addi x1, x0, 0x180
L 03 19000113 # addi x2, x0, 0x190
L 04 00000193 # addi x3, x0, 0
L 05 0000A203 # lw x4, 0(x1)
L 06 004181B3 # add x3, x3, x4
L 07 00408093 # addi x1, x1, 4
L 08 FE209AE3 # bne x1, x2, -12
L 09 00C002EF # jal x5, +12
L 0A 00000000
L 0B 00000000
L 0C FFF00313 # addi x6, x0, -1
L 0D 00334463 # blt x6, x3, +8
L 0E 00000000
L 0F 0061F463 # bgeu x3, x6, +8 not taken
L 10 00337463 # bgeu x6, x3, +8
L 11 00000000
L 12 028283E7 # jalr x7, 40(x5)
L 13 00000000
L 14 14302223 # sw x3, 0x144(x0)
L 15 14702423 # sw x7, 0x148(x0)
L 16 14502623 # sw x5, 0x14c(x0)
L 17 00000073 # ecall
R
S 1 0
C 50 00000000
C 51 0000110C
C 52 0000004C
C 53 00000028
# MUL is outside the supported set.
L 58 11111111
L 59 22222222
L 00 00300093 # addi x1, x0, 3
L 01 16102023 # sw x1, 0x160(x0)
L 02 02108133 # mul x2, x1, x1
L 03 16102223 # sw x1, 0x164(x0)
L 04 00000073 # ecall
R
S 0 1
C 58 00000003
C 59 22222222
# Undefined opcode.
L 5A 33333333
L 5B 44444444
L 00 00900093 # addi x1, x0, 9
L 01 16102423 # sw x1, 0x168(x0)
L 02 0000002B # custom opcode
L 03 16102623 # sw x1, 0x16c(x0)
L 04 00000073 # ecall
R
S 0 1
C 5A 00000009
C 5B 44444444
# EBREAK, then a second program that must start again from pc 0.
L 5D 66666666
L 00 07700093 # addi x1, x0, 0x77
L 01 16102823 # sw x1, 0x170(x0)
L 02 00100073 # ebreak
R
S 1 0
C 5C 00000077
L 00 05500113 # addi x2, x0, 0x55
L 01 16202A23 # sw x2, 0x174(x0)
L 02 00000073 # ecall
R
S 1 0
C 5C 00000077
C 5D 00000055

// ==== tb.f ====
hw/rv_pkg.sv
hw/inst_decode.sv
hw/rv_alu.sv
hw/rv_regfile.sv
hw/mem_arbiter.sv
hw/word_ram.sv
hw/rv_core.sv
hw/rv_system.sv
bench/tb_rv_system.sv

// ==== Makefile ====
# Verilator build of the rv_system testbench, run from the project root.

VERILATOR ?= verilator
TOP       ?= tb_rv_system
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --timing --timescale 1ns/1ns

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
